// File: Makefile
VERILATOR ?= verilator
TOP       ?= loop_engine_tb
LINT_TOP  ?= loop_engine_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
+incdir+source
source/loop_pkg.sv
source/loop_table.sv
source/loop_wb_slave.sv
source/loop_sequencer.sv
source/loop_iter_counters.sv
source/loop_addr_gen.sv
source/loop_engine_top.sv
test/loop_engine_assertions.sv
test/loop_engine_tb.sv

// File: source/loop_addr_gen.sv
`timescale 1ns/100ps
`include "loop_params.svh"

module loop_addr_gen (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    step_en_i,
  input  logic [`LOOP_PTR_W-1:0]  ptr_i,
  input  loop_pkg::op_t           op_i,
  input  logic [`LOOP_ITR_W-1:0]  itr_i_i,
  input  logic [`LOOP_ITR_W-1:0]  itr_j_i,
  input  logic [`LOOP_ITR_W-1:0]  itr_k_i,
  input  logic [`LOOP_ADDR_W-1:0] base_i,
  input  logic [`LOOP_ADDR_W-1:0] stride_i_i,
  input  logic [`LOOP_ADDR_W-1:0] stride_j_i,
  input  logic [`LOOP_ADDR_W-1:0] stride_k_i,
  output logic                    step_valid_o,
  output logic [`LOOP_PTR_W-1:0]  step_ptr_o,
  output loop_pkg::op_t           step_op_o,
  output logic [`LOOP_ITR_W-1:0]  step_itr_i_o,
  output logic [`LOOP_ITR_W-1:0]  step_itr_j_o,
  output logic [`LOOP_ITR_W-1:0]  step_itr_k_o,
  output logic [`LOOP_ADDR_W-1:0] step_addr_o
);

  localparam int PAD_W = `LOOP_ADDR_W - `LOOP_ITR_W;

  logic [`LOOP_ADDR_W-1:0] ext_i; // iterators widened to address width
  logic [`LOOP_ADDR_W-1:0] ext_j;
  logic [`LOOP_ADDR_W-1:0] ext_k;
  logic [`LOOP_ADDR_W-1:0] addr_c;

  assign ext_i  = {{PAD_W{1'b0}}, itr_i_i};
  assign ext_j  = {{PAD_W{1'b0}}, itr_j_i};
  assign ext_k  = {{PAD_W{1'b0}}, itr_k_i};
  assign addr_c = base_i + ext_i * stride_i_i + ext_j * stride_j_i + ext_k * stride_k_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      step_valid_o <= 1'b0;
    end else begin
      step_valid_o <= step_en_i; // one cycle after EXEC
    end
  end

  always_ff @(posedge clk) begin
    if (step_en_i) begin
      step_ptr_o   <= ptr_i;
      step_op_o    <= op_i;
      step_itr_i_o <= itr_i_i; // values before this cycle's update
      step_itr_j_o <= itr_j_i;
      step_itr_k_o <= itr_k_i;
      step_addr_o  <= addr_c;  // wraps mod 2^24
    end
  end

endmodule

// File: source/loop_engine_top.sv
`timescale 1ns/100ps
`include "loop_params.svh"

module loop_engine_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [`LOOP_WB_AW-1:0]  wb_adr_i,
  input  logic [31:0]             wb_dat_i,
  input  logic [3:0]              wb_sel_i,
  output logic [31:0]             wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    step_valid_o,
  output logic [`LOOP_PTR_W-1:0]  step_ptr_o,
  output loop_pkg::op_t           step_op_o,
  output logic [`LOOP_ITR_W-1:0]  step_itr_i_o,
  output logic [`LOOP_ITR_W-1:0]  step_itr_j_o,
  output logic [`LOOP_ITR_W-1:0]  step_itr_k_o,
  output logic [`LOOP_ADDR_W-1:0] step_addr_o,
  output logic                    busy_o,
  output logic                    done_o
);

  import loop_pkg::*;

  logic                    ent_we;
  logic                    cfg_we;
  logic [`LOOP_PTR_W-1:0]  tbl_waddr;
  logic [31:0]             tbl_wdata;
  logic [`LOOP_PTR_W-1:0]  tbl_raddr;
  entry_t                  ent_wdata;
  entry_t                  ent_rdata;
  op_t                     cfg_wdata;
  op_t                     cfg_rdata;
  logic                    start;
  logic [`LOOP_ADDR_W-1:0] stride_i;
  logic [`LOOP_ADDR_W-1:0] stride_j;
  logic [`LOOP_ADDR_W-1:0] stride_k;
  logic [`LOOP_ADDR_W-1:0] base;
  level_e                  cnt_level;
  logic                    cnt_load;
  logic                    cnt_inc;
  logic                    cnt_clr;
  logic                    cnt_clr_all;
  logic [`LOOP_ITR_W-1:0]  trip;
  logic [`LOOP_ITR_W-1:0]  itr_i;
  logic [`LOOP_ITR_W-1:0]  itr_j;
  logic [`LOOP_ITR_W-1:0]  itr_k;
  logic                    last_i;
  logic                    last_j;
  logic                    last_k;
  logic                    step_en;
  logic [`LOOP_PTR_W-1:0]  seq_ptr;
  op_t                     seq_op;

  assign ent_wdata = entry_t'(tbl_wdata[30:0]); // bit 31 spare
  assign cfg_wdata = op_t'(tbl_wdata[15:0]);    // tag in the low half

  loop_table #(.payload_t(entry_t)) u_ent_tbl (
    .clk(clk), .we_i(ent_we), .waddr_i(tbl_waddr), .wdata_i(ent_wdata),
    .raddr_i(tbl_raddr), .rdata_o(ent_rdata)
  );

  loop_table #(.payload_t(op_t)) u_cfg_tbl (
    .clk(clk), .we_i(cfg_we), .waddr_i(tbl_waddr), .wdata_i(cfg_wdata),
    .raddr_i(tbl_raddr), .rdata_o(cfg_rdata)
  );

  loop_wb_slave u_slave (
    .clk(clk), .rst(rst),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .busy_i(busy_o), .done_i(done_o), .ent_we_o(ent_we), .cfg_we_o(cfg_we),
    .tbl_waddr_o(tbl_waddr), .tbl_wdata_o(tbl_wdata), .start_o(start),
    .stride_i_o(stride_i), .stride_j_o(stride_j), .stride_k_o(stride_k), .base_o(base)
  );

  loop_sequencer u_seq (
    .clk(clk), .rst(rst), .start_i(start), .entry_i(ent_rdata), .op_i(cfg_rdata),
    .raddr_o(tbl_raddr), .last_i_i(last_i), .last_j_i(last_j), .last_k_i(last_k),
    .cnt_level_o(cnt_level), .cnt_load_o(cnt_load), .cnt_inc_o(cnt_inc),
    .cnt_clr_o(cnt_clr), .cnt_clr_all_o(cnt_clr_all), .trip_o(trip),
    .step_en_o(step_en), .step_ptr_o(seq_ptr), .step_op_o(seq_op),
    .busy_o(busy_o), .done_o(done_o)
  );

  loop_iter_counters u_cnt (
    .clk(clk), .rst(rst), .level_i(cnt_level), .load_i(cnt_load), .trip_i(trip),
    .inc_i(cnt_inc), .clr_i(cnt_clr), .clr_all_i(cnt_clr_all),
    .itr_i_o(itr_i), .itr_j_o(itr_j), .itr_k_o(itr_k),
    .last_i_o(last_i), .last_j_o(last_j), .last_k_o(last_k)
  );

  loop_addr_gen u_agen (
    .clk(clk), .rst(rst), .step_en_i(step_en), .ptr_i(seq_ptr), .op_i(seq_op),
    .itr_i_i(itr_i), .itr_j_i(itr_j), .itr_k_i(itr_k), .base_i(base),
    .stride_i_i(stride_i), .stride_j_i(stride_j), .stride_k_i(stride_k),
    .step_valid_o(step_valid_o), .step_ptr_o(step_ptr_o), .step_op_o(step_op_o),
    .step_itr_i_o(step_itr_i_o), .step_itr_j_o(step_itr_j_o),
    .step_itr_k_o(step_itr_k_o), .step_addr_o(step_addr_o)
  );

endmodule

// File: source/loop_iter_counters.sv
`timescale 1ns/100ps
`include "loop_params.svh"

module loop_iter_counters (
  input  logic                   clk,
  input  logic                   rst,
  input  loop_pkg::level_e       level_i,
  input  logic                   load_i,
  input  logic [`LOOP_ITR_W-1:0] trip_i,
  input  logic                   inc_i,
  input  logic                   clr_i,
  input  logic                   clr_all_i,
  output logic [`LOOP_ITR_W-1:0] itr_i_o,
  output logic [`LOOP_ITR_W-1:0] itr_j_o,
  output logic [`LOOP_ITR_W-1:0] itr_k_o,
  output logic                   last_i_o,
  output logic                   last_j_o,
  output logic                   last_k_o
);

  import loop_pkg::*;

  localparam logic [`LOOP_ITR_W-1:0] ITR_ONE = 1;

  logic [`LOOP_ITR_W-1:0] itr_q  [3]; // indexed by level code
  logic [`LOOP_ITR_W-1:0] trip_q [3];
  logic [2:0]             last;

  always_comb begin
    logic [`LOOP_ITR_W-1:0] eff;
    for (int l = 0; l < 3; l++) begin
      eff     = (trip_q[l] == '0) ? ITR_ONE : trip_q[l]; // trip 0 runs once
      last[l] = (itr_q[l] == eff - ITR_ONE);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int l = 0; l < 3; l++) begin
        itr_q[l]  <= '0;
        trip_q[l] <= '0;
      end
    end else begin
      for (int l = 0; l < 3; l++) begin
        if (clr_all_i) begin
          itr_q[l] <= '0; // new run
        end else if (level_i == level_e'(l)) begin
          if (load_i) begin
            trip_q[l] <= trip_i;
          end
          if (clr_i) begin
            itr_q[l] <= '0;
          end else if (inc_i) begin
            itr_q[l] <= itr_q[l] + ITR_ONE;
          end
        end
      end
    end
  end

  assign itr_i_o  = itr_q[LVL_I];
  assign itr_j_o  = itr_q[LVL_J];
  assign itr_k_o  = itr_q[LVL_K];
  assign last_i_o = last[LVL_I];
  assign last_j_o = last[LVL_J];
  assign last_k_o = last[LVL_K];

endmodule

// File: source/loop_params.svh
`ifndef LOOP_PARAMS_SVH
`define LOOP_PARAMS_SVH

`define LOOP_PTR_W  6                  // table pointer width
`define LOOP_DEPTH  (1 << `LOOP_PTR_W) // 64 slots per table
`define LOOP_ITR_W  16                 // iterators and trip counts
`define LOOP_ADDR_W 24                 // linear address, strides, base
`define LOOP_WB_AW  10                 // wishbone byte address

// regions by adr[9:8]
`define LOOP_RGN_ENT 2'b00 // entry table 0x000-0x0fc
`define LOOP_RGN_CFG 2'b01 // config table 0x100-0x1fc

// register map
`define LOOP_ADR_CTRL     10'h200 // bit 0 starts a run
`define LOOP_ADR_STATUS   10'h204 // bit 0 busy, bit 1 done
`define LOOP_ADR_STRIDE_I 10'h208
`define LOOP_ADR_STRIDE_J 10'h20c
`define LOOP_ADR_STRIDE_K 10'h210
`define LOOP_ADR_BASE     10'h214

`endif

// File: source/loop_pkg.sv
`include "loop_params.svh"

package loop_pkg;

  typedef enum logic [1:0] {
    LVL_K = 2'd0, // innermost
    LVL_J = 2'd1,
    LVL_I = 2'd2  // outermost
  } level_e;

  typedef enum logic [1:0] {
    KIND_INIT = 2'd0, // loop header, loads trip and label
    KIND_BODY = 2'd1  // statement, last slot is also the check-end
  } kind_e;

  // operation tag, one per table slot in the config table
  typedef logic [15:0] op_t;

  // one 32-bit wishbone word, bit 31 spare
  typedef struct packed {
    logic [`LOOP_ITR_W-1:0] trip;   // bits 30:15, trip count for init
    kind_e                  kind;   // bits 14:13
    logic [4:0]             num_sc; // bits 12:8, slots in the level
    logic [4:0]             sc;     // bits 7:3, slot index
    level_e                 level;  // bits 2:1
    logic                   valid;  // bit 0, clear ends the run
  } entry_t;

endpackage

// File: source/loop_sequencer.sv
`timescale 1ns/100ps
`include "loop_params.svh"

module loop_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  input  loop_pkg::entry_t       entry_i,
  input  loop_pkg::op_t          op_i,
  output logic [`LOOP_PTR_W-1:0] raddr_o,
  input  logic                   last_i_i,
  input  logic                   last_j_i,
  input  logic                   last_k_i,
  output loop_pkg::level_e       cnt_level_o,
  output logic                   cnt_load_o,
  output logic                   cnt_inc_o,
  output logic                   cnt_clr_o,
  output logic                   cnt_clr_all_o,
  output logic [`LOOP_ITR_W-1:0] trip_o,
  output logic                   step_en_o,
  output logic [`LOOP_PTR_W-1:0] step_ptr_o,
  output loop_pkg::op_t          step_op_o,
  output logic                   busy_o,
  output logic                   done_o
);

  import loop_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH, // read address out
    S_EXEC,  // entry and op tag present
    S_DONE
  } state_e;

  localparam logic [`LOOP_PTR_W-1:0] PTR_ONE = 1;

  state_e                 state_q;
  logic [`LOOP_PTR_W-1:0] ptr_q;
  logic [`LOOP_PTR_W-1:0] lbl_k_q;  // first slot after each init
  logic [`LOOP_PTR_W-1:0] lbl_j_q;
  logic [`LOOP_PTR_W-1:0] lbl_i_q;
  logic                   go;       // start taken
  logic                   ent_ok;   // entry keeps the run alive
  logic                   is_init;
  logic                   is_body;
  logic                   at_end;   // last slot, check-end applies
  logic                   lvl_last; // last flag of the entry level
  logic [`LOOP_PTR_W-1:0] lvl_lbl;  // label of the entry level
  logic [`LOOP_PTR_W-1:0] ptr_nxt;

  assign go      = start_i & ((state_q == S_IDLE) | (state_q == S_DONE)); // busy drops it
  assign ent_ok  = entry_i.valid & (entry_i.level != 2'd3) &
                   ((entry_i.kind == KIND_INIT) | (entry_i.kind == KIND_BODY));
  assign is_init = (state_q == S_EXEC) & ent_ok & (entry_i.kind == KIND_INIT);
  assign is_body = (state_q == S_EXEC) & ent_ok & (entry_i.kind == KIND_BODY);
  assign at_end  = (entry_i.sc == entry_i.num_sc - 5'd1);

  always_comb begin
    case (entry_i.level)
      LVL_I: begin
        lvl_last = last_i_i;
        lvl_lbl  = lbl_i_q;
      end
      LVL_J: begin
        lvl_last = last_j_i;
        lvl_lbl  = lbl_j_q;
      end
      default: begin
        lvl_last = last_k_i;
        lvl_lbl  = lbl_k_q;
      end
    endcase
  end

  assign raddr_o       = ptr_q; // table registers it in FETCH
  assign cnt_level_o   = entry_i.level;
  assign trip_o        = entry_i.trip;
  assign cnt_load_o    = is_init;
  assign cnt_inc_o     = is_body & at_end & ~lvl_last; // another pass
  assign cnt_clr_o     = is_body & at_end & lvl_last;  // level finished
  assign cnt_clr_all_o = go;
  assign step_en_o     = is_body;
  assign step_ptr_o    = ptr_q;
  assign step_op_o     = op_i;
  assign busy_o        = (state_q == S_FETCH) | (state_q == S_EXEC);
  assign done_o        = (state_q == S_DONE);

  assign ptr_nxt = cnt_inc_o ? lvl_lbl : ptr_q + PTR_ONE; // jump back or fall through

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      ptr_q   <= '0;
      lbl_k_q <= '0;
      lbl_j_q <= '0;
      lbl_i_q <= '0;
    end else begin
      case (state_q)
        S_IDLE, S_DONE: begin
          if (go) begin
            state_q <= S_FETCH;
            ptr_q   <= '0; // program always starts at slot 0
          end
        end
        S_FETCH: state_q <= S_EXEC;
        S_EXEC: begin
          if (!ent_ok) begin
            state_q <= S_DONE; // busy and done flip together
          end else begin
            state_q <= S_FETCH;
            ptr_q   <= ptr_nxt;
          end
        end
        default: state_q <= S_IDLE;
      endcase
      if (is_init) begin
        case (entry_i.level)
          LVL_I:   lbl_i_q <= ptr_q + PTR_ONE;
          LVL_J:   lbl_j_q <= ptr_q + PTR_ONE;
          default: lbl_k_q <= ptr_q + PTR_ONE;
        endcase
      end
    end
  end

endmodule

// File: source/loop_table.sv
`timescale 1ns/100ps
`include "loop_params.svh"

module loop_table #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                   clk,
  input  logic                   we_i,
  input  logic [`LOOP_PTR_W-1:0] waddr_i,
  input  payload_t               wdata_i,
  input  logic [`LOOP_PTR_W-1:0] raddr_i,
  output payload_t               rdata_o
);

  payload_t mem_q [`LOOP_DEPTH]; // one word per slot

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i; // host load
    end
    rdata_o <= mem_q[raddr_i]; // data one cycle after the address
  end

endmodule

// File: source/loop_wb_slave.sv
`timescale 1ns/100ps
`include "loop_params.svh"

module loop_wb_slave (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [`LOOP_WB_AW-1:0]  wb_adr_i,
  input  logic [31:0]             wb_dat_i,
  input  logic [3:0]              wb_sel_i,
  output logic [31:0]             wb_dat_o,
  output logic                    wb_ack_o,
  input  logic                    busy_i,
  input  logic                    done_i,
  output logic                    ent_we_o,
  output logic                    cfg_we_o,
  output logic [`LOOP_PTR_W-1:0]  tbl_waddr_o,
  output logic [31:0]             tbl_wdata_o,
  output logic                    start_o,
  output logic [`LOOP_ADDR_W-1:0] stride_i_o,
  output logic [`LOOP_ADDR_W-1:0] stride_j_o,
  output logic [`LOOP_ADDR_W-1:0] stride_k_o,
  output logic [`LOOP_ADDR_W-1:0] base_o
);

  logic        req;        // cycle seen, not acked yet
  logic        wr;
  logic [1:0]  rgn;        // table region select
  logic        start_pend; // ctrl write taken, pulse follows the ack
  logic [31:0] rd_data;

  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o; // ack blocks a second hit
  assign wr  = req & wb_we_i;
  assign rgn = wb_adr_i[`LOOP_WB_AW-1:8];

  // table writes pass on the request cycle, whole words only
  assign tbl_waddr_o = wb_adr_i[`LOOP_PTR_W+1:2];
  assign tbl_wdata_o = wb_dat_i;
  assign ent_we_o    = wr & (rgn == `LOOP_RGN_ENT) & (&wb_sel_i);
  assign cfg_we_o    = wr & (rgn == `LOOP_RGN_CFG) & (&wb_sel_i);

  // byte lane merge, top lane falls off the 24-bit register
  function automatic logic [`LOOP_ADDR_W-1:0] merge_sel(
    input logic [`LOOP_ADDR_W-1:0] old_v,
    input logic [31:0]             new_v,
    input logic [3:0]              sel
  );
    logic [31:0] r;
    r = 32'(old_v);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        r[b*8 +: 8] = new_v[b*8 +: 8];
      end
    end
    return r[`LOOP_ADDR_W-1:0];
  endfunction

  always_comb begin
    case (wb_adr_i)
      `LOOP_ADR_STATUS:   rd_data = {30'd0, done_i, busy_i};
      `LOOP_ADR_STRIDE_I: rd_data = 32'(stride_i_o);
      `LOOP_ADR_STRIDE_J: rd_data = 32'(stride_j_o);
      `LOOP_ADR_STRIDE_K: rd_data = 32'(stride_k_o);
      `LOOP_ADR_BASE:     rd_data = 32'(base_o);
      default:            rd_data = 32'd0; // tables, ctrl, holes
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack_o   <= 1'b0;
      wb_dat_o   <= 32'd0;
      start_pend <= 1'b0;
      start_o    <= 1'b0;
      stride_i_o <= '0;
      stride_j_o <= '0;
      stride_k_o <= '0;
      base_o     <= '0;
    end else begin
      wb_ack_o   <= req; // single-cycle ack
      wb_dat_o   <= (req & ~wb_we_i) ? rd_data : 32'd0;
      start_pend <= wr & (wb_adr_i == `LOOP_ADR_CTRL) & wb_sel_i[0] & wb_dat_i[0] & ~busy_i;
      start_o    <= start_pend; // pulse in the cycle after ack
      if (wr) begin
        case (wb_adr_i)
          `LOOP_ADR_STRIDE_I: stride_i_o <= merge_sel(stride_i_o, wb_dat_i, wb_sel_i);
          `LOOP_ADR_STRIDE_J: stride_j_o <= merge_sel(stride_j_o, wb_dat_i, wb_sel_i);
          `LOOP_ADR_STRIDE_K: stride_k_o <= merge_sel(stride_k_o, wb_dat_i, wb_sel_i);
          `LOOP_ADR_BASE:     base_o     <= merge_sel(base_o, wb_dat_i, wb_sel_i);
          default: ; // unmapped writes dropped
        endcase
      end
    end
  end

endmodule

// File: test/loop_engine_assertions.sv
`timescale 1ns/100ps

module loop_engine_assertions (
  input logic clk,
  input logic rst,
  input logic ack_i,
  input logic step_valid_i,
  input logic busy_i,
  input logic done_i
);

  // classic slave acks once per access
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack_i |=> !ack_i)
    else $error("wishbone ack stayed high for more than one cycle");

  // step is registered from EXEC, so busy was up a cycle earlier
  step_in_run: assert property (@(posedge clk) disable iff (rst) step_valid_i |-> $past(busy_i))
    else $error("step output valid without a run in the previous cycle");

  // run end hands busy over to done on one edge
  busy_to_done: assert property (@(posedge clk) disable iff (rst)
    $fell(busy_i) == $rose(done_i))
    else $error("busy fell and done rose on different cycles");

endmodule

bind loop_engine_top loop_engine_assertions u_assert (
  .clk(clk),
  .rst(rst),
  .ack_i(wb_ack_o),
  .step_valid_i(step_valid_o),
  .busy_i(busy_o),
  .done_i(done_o)
);

// File: test/loop_engine_tb.sv
`timescale 1ns/100ps
`include "loop_params.svh"

module loop_engine_tb;

  import loop_pkg::*;

  // longest test is two runs of a nest with trips up to 3 (under 70 entry visits each,
  // 2 cycles a visit) plus about 2 cycles per bus access; 4000 leaves a wide margin
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int DEPTH          = `LOOP_DEPTH;
  localparam int VISIT_LIMIT    = 2000; // model gives up on a runaway program

  typedef struct packed {
    logic [`LOOP_PTR_W-1:0]  ptr;
    logic [15:0]             op;
    logic [`LOOP_ITR_W-1:0]  itr_i;
    logic [`LOOP_ITR_W-1:0]  itr_j;
    logic [`LOOP_ITR_W-1:0]  itr_k;
    logic [`LOOP_ADDR_W-1:0] addr;
  } step_t;

  logic                    clk;
  logic                    rst;
  logic                    wb_cyc_i;
  logic                    wb_stb_i;
  logic                    wb_we_i;
  logic [`LOOP_WB_AW-1:0]  wb_adr_i;
  logic [31:0]             wb_dat_i;
  logic [3:0]              wb_sel_i;
  logic [31:0]             wb_dat_o;
  logic                    wb_ack_o;
  logic                    step_valid_o;
  logic [`LOOP_PTR_W-1:0]  step_ptr_o;
  op_t                     step_op_o;
  logic [`LOOP_ITR_W-1:0]  step_itr_i_o;
  logic [`LOOP_ITR_W-1:0]  step_itr_j_o;
  logic [`LOOP_ITR_W-1:0]  step_itr_k_o;
  logic [`LOOP_ADDR_W-1:0] step_addr_o;
  logic                    busy_o;
  logic                    done_o;

  integer                  seed;
  int                      cycle_cnt = 0;
  int                      step_cnt;  // steps seen in the current run
  string                   cur_test;
  step_t                   exp_q [$]; // expected steps, oldest first
  step_t                   exp_s;
  logic                    p_valid [DEPTH]; // host copy of the loaded program
  logic [1:0]              p_level [DEPTH];
  logic [4:0]              p_sc    [DEPTH];
  logic [4:0]              p_num   [DEPTH];
  logic [1:0]              p_kind  [DEPTH];
  logic [15:0]             p_trip  [DEPTH];
  op_t                     p_op    [DEPTH];
  logic [`LOOP_ADDR_W-1:0] sh_base;
  logic [`LOOP_ADDR_W-1:0] sh_stride_i;
  logic [`LOOP_ADDR_W-1:0] sh_stride_j;
  logic [`LOOP_ADDR_W-1:0] sh_stride_k;

  loop_engine_top loop_engine_i (.*);

  always #10 clk = ~clk; // 20 ns period

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      abort_run("value mismatch");
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: run still going after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // outputs settle after posedge, so look at them half a period later
  always @(negedge clk) begin
    if (!rst && step_valid_o) begin
      if (exp_q.size() == 0) begin
        abort_run($sformatf("%s: step at ptr %0d came when no step was expected",
                            cur_test, step_ptr_o));
      end else begin
        exp_s = exp_q.pop_front();
        check_val("step ptr", exp_s.ptr, step_ptr_o);
        check_val("step op", exp_s.op, step_op_o);
        check_val("step i", exp_s.itr_i, step_itr_i_o);
        check_val("step j", exp_s.itr_j, step_itr_j_o);
        check_val("step k", exp_s.itr_k, step_itr_k_o);
        check_val("step addr", exp_s.addr, step_addr_o);
        step_cnt++;
      end
    end
  end

  function automatic int pick(input int span);
    return 1 + int'($unsigned($random(seed)) % span); // 1..span
  endfunction

  task automatic wb_write(input logic [`LOOP_WB_AW-1:0] adr, input logic [31:0] dat);
    @(negedge clk);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = 4'hf;
    do @(negedge clk); while (!wb_ack_o);
    wb_cyc_i = 1'b0; // drop stb once ack is seen
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_read(input logic [`LOOP_WB_AW-1:0] adr, output logic [31:0] dat);
    @(negedge clk);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr;
    wb_sel_i = 4'hf;
    do @(negedge clk); while (!wb_ack_o);
    dat      = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  task automatic put_entry(input logic [5:0] idx, input logic [1:0] lvl, input logic [1:0] kind,
                           input logic [4:0] sc, input logic [4:0] num, input logic [15:0] trip,
                           input logic [15:0] op);
    p_valid[idx] = 1'b1;
    p_level[idx] = lvl;
    p_sc[idx]    = sc;
    p_num[idx]   = num;
    p_kind[idx]  = kind;
    p_trip[idx]  = trip;
    p_op[idx]    = op;
    wb_write({2'b00, idx, 2'b00}, {1'b0, trip, kind, num, sc, lvl, 1'b1}); // entry word
    wb_write({2'b01, idx, 2'b00}, {16'd0, op});                            // config word
  endtask

  task automatic put_end(input logic [5:0] idx);
    p_valid[idx] = 1'b0;
    wb_write({2'b00, idx, 2'b00}, 32'd0);
  endtask

  task automatic set_geometry(input logic [23:0] b, input logic [23:0] si,
                              input logic [23:0] sj, input logic [23:0] sk);
    sh_base     = b;
    sh_stride_i = si;
    sh_stride_j = sj;
    sh_stride_k = sk;
    wb_write(`LOOP_ADR_BASE, {8'd0, b});
    wb_write(`LOOP_ADR_STRIDE_I, {8'd0, si});
    wb_write(`LOOP_ADR_STRIDE_J, {8'd0, sj});
    wb_write(`LOOP_ADR_STRIDE_K, {8'd0, sk});
  endtask

  // walks the host copy of the program by the sequencer rules
  task automatic expand_program();
    int          ptr;
    int          visits;
    int          lv;
    int          eff;
    int          lbl  [3];
    int          itr  [3];
    int          trip [3];
    logic [63:0] a;
    step_t       s;
    ptr    = 0;
    visits = 0;
    for (int l = 0; l < 3; l++) begin
      lbl[l]  = 0;
      itr[l]  = 0;
      trip[l] = 0;
    end
    exp_q.delete();
    while (p_valid[ptr] && p_level[ptr] != 2'd3 && p_kind[ptr] <= 2'd1) begin
      if (visits >= VISIT_LIMIT) begin
        abort_run("reference model never reached the end of the program");
      end
      visits++;
      lv = int'(p_level[ptr]);
      if (p_kind[ptr] == 2'd0) begin // init: trip and label
        trip[lv] = int'(p_trip[ptr]);
        lbl[lv]  = (ptr + 1) % DEPTH;
        ptr      = (ptr + 1) % DEPTH;
      end else begin
        s.ptr   = 6'(ptr);
        s.op    = p_op[ptr];
        s.itr_i = 16'(itr[2]);
        s.itr_j = 16'(itr[1]);
        s.itr_k = 16'(itr[0]);
        a = 64'(sh_base) + 64'(itr[2]) * 64'(sh_stride_i) + 64'(itr[1]) * 64'(sh_stride_j)
            + 64'(itr[0]) * 64'(sh_stride_k);
        s.addr = a[23:0];
        exp_q.push_back(s);
        eff = (trip[lv] == 0) ? 1 : trip[lv]; // trip 0 acts as 1
        if (p_sc[ptr] != p_num[ptr] - 5'd1) begin
          ptr = (ptr + 1) % DEPTH;
        end else if (itr[lv] + 1 >= eff) begin
          itr[lv] = 0; // level done, fall through
          ptr     = (ptr + 1) % DEPTH;
        end else begin
          itr[lv] = itr[lv] + 1;
          ptr     = lbl[lv];
        end
      end
    end
  endtask

  task automatic start_run();
    wb_write(`LOOP_ADR_CTRL, 32'd1);
    while (!busy_o) @(negedge clk);
  endtask

  task automatic wait_done();
    while (!done_o) @(negedge clk);
  endtask

  task automatic run_and_check();
    int n;
    n        = exp_q.size();
    step_cnt = 0;
    start_run();
    wait_done();
    check_val("step count", n, step_cnt);
  endtask

  task automatic load_nest(input logic [15:0] ti, input logic [15:0] tj, input logic [15:0] tk);
    put_entry(6'd0, LVL_I, KIND_INIT, 5'd0, 5'd1, ti, 16'h0000);
    put_entry(6'd1, LVL_J, KIND_INIT, 5'd0, 5'd1, tj, 16'h0000);
    put_entry(6'd2, LVL_K, KIND_INIT, 5'd0, 5'd1, tk, 16'h0000);
    put_entry(6'd3, LVL_K, KIND_BODY, 5'd0, 5'd1, 16'd0, 16'h3a01); // k body, own check-end
    put_entry(6'd4, LVL_J, KIND_BODY, 5'd0, 5'd2, 16'd0, 16'h3a02);
    put_entry(6'd5, LVL_J, KIND_BODY, 5'd1, 5'd2, 16'd0, 16'h3a03); // back to k init
    put_entry(6'd6, LVL_I, KIND_BODY, 5'd0, 5'd2, 16'd0, 16'h3a04);
    put_entry(6'd7, LVL_I, KIND_BODY, 5'd1, 5'd2, 16'd0, 16'h3a05);
    put_end(6'd8);
  endtask

  task automatic test_regs();
    logic [31:0] rd;
    logic [23:0] b;
    logic [23:0] si;
    logic [23:0] sj;
    logic [23:0] sk;
    cur_test = "regs";
    wb_read(`LOOP_ADR_STATUS, rd);
    check_val("status after reset", 0, rd);
    b  = 24'($random(seed));
    si = 24'($random(seed));
    sj = 24'($random(seed));
    sk = 24'($random(seed));
    set_geometry(b, si, sj, sk);
    wb_read(`LOOP_ADR_BASE, rd);
    check_val("base", {8'd0, b}, rd);
    wb_read(`LOOP_ADR_STRIDE_I, rd);
    check_val("stride_i", {8'd0, si}, rd);
    wb_read(`LOOP_ADR_STRIDE_J, rd);
    check_val("stride_j", {8'd0, sj}, rd);
    wb_read(`LOOP_ADR_STRIDE_K, rd);
    check_val("stride_k", {8'd0, sk}, rd);
    wb_read(10'h3f0, rd); // hole in the map
    check_val("unmapped read", 0, rd);
  endtask

  task automatic test_single_k();
    step_t       s;
    logic [63:0] a;
    int          n;
    cur_test = "single k";
    set_geometry(24'(pick(4096)), 24'(pick(64)), 24'(pick(64)), 24'(pick(64)));
    put_entry(6'd0, LVL_K, KIND_INIT, 5'd0, 5'd1, 16'd5, 16'h0000);
    put_entry(6'd1, LVL_K, KIND_BODY, 5'd0, 5'd1, 16'd0, 16'h00a1);
    put_end(6'd2);
    exp_q.delete();
    for (int k = 0; k < 5; k++) begin // built straight from the loop's meaning
      a       = 64'(sh_base) + 64'(k) * 64'(sh_stride_k);
      s.ptr   = 6'd1;
      s.op    = 16'h00a1;
      s.itr_i = '0;
      s.itr_j = '0;
      s.itr_k = 16'(k);
      s.addr  = a[23:0];
      exp_q.push_back(s);
    end
    step_cnt = 0;
    wb_write(`LOOP_ADR_CTRL, 32'd1);
    n = 0;
    while (!step_valid_o) begin // cycles from ack to the first step
      @(negedge clk);
      n++;
    end
    check_val("first step latency", 4 + 2, n); // init at entry 0 costs one 2-cycle visit
    wait_done();
    check_val("step count", 5, step_cnt);
  endtask

  task automatic test_nest();
    cur_test = "nest";
    set_geometry(24'(pick(4096)), 24'(pick(256)), 24'(pick(64)), 24'(pick(16)));
    load_nest(16'(pick(3)), 16'(pick(3)), 16'(pick(3)));
    expand_program();
    run_and_check();
  endtask

  task automatic test_empty();
    logic [31:0] rd;
    cur_test = "empty";
    put_end(6'd0);
    expand_program();
    run_and_check();
    wb_read(`LOOP_ADR_STATUS, rd);
    check_val("status done", 2, rd);
  endtask

  task automatic test_restart();
    logic [31:0] rd;
    cur_test = "restart";
    load_nest(16'(pick(2) + 1), 16'(pick(2) + 1), 16'(pick(2) + 1)); // long enough to poke
    expand_program();
    step_cnt = 0;
    start_run();
    wb_read(`LOOP_ADR_STATUS, rd);
    check_val("status busy", 1, rd);
    wb_write(`LOOP_ADR_CTRL, 32'd1); // lands while busy
    wait_done();
    check_val("steps left", 0, exp_q.size());
    wb_read(`LOOP_ADR_STATUS, rd);
    check_val("status done", 2, rd);
    expand_program(); // same program, same sequence
    run_and_check();
  endtask

  task automatic test_trip0();
    cur_test = "trip zero";
    put_entry(6'd0, LVL_J, KIND_INIT, 5'd0, 5'd1, 16'd2, 16'h0000);
    put_entry(6'd1, LVL_K, KIND_INIT, 5'd0, 5'd1, 16'd0, 16'h0000);
    put_entry(6'd2, LVL_K, KIND_BODY, 5'd0, 5'd1, 16'd0, 16'h0c01);
    put_entry(6'd3, LVL_J, KIND_BODY, 5'd0, 5'd1, 16'd0, 16'h0c02);
    put_end(6'd4);
    expand_program();
    check_val("expected steps", 4, exp_q.size()); // k body once per j pass
    run_and_check();
  endtask

  initial begin
    seed     = 32'hbc03;
    clk      = 1'b0;
    rst      = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    cur_test = "reset";
    step_cnt = 0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    test_regs();
    test_single_k();
    test_nest();
    test_empty();
    test_restart();
    test_trip0();
    $display("test passed");
    $finish;
  end

endmodule
